// ==== bench/conv_engine_properties.sv ====
// output stream protocol assertions, bound to the conv engine top
`timescale 1ns/10ps

module conv_engine_properties (
  input logic                        clk,
  input logic                        rstn,
  input logic [conv_pkg::DATA_W-1:0] m_tdata,
  input logic                        m_tvalid,
  input logic                        m_tready,
  input logic                        m_tlast,
  input logic                        done
);

  // a word on offer stays until it is taken
  a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && !m_tready |=> m_tvalid)
    else $error("m_tvalid dropped before the transfer");

  a_data_stable: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && !m_tready |=> $stable(m_tdata))
    else $error("m_tdata changed while the transfer was pending");

  a_last_valid: assert property (@(posedge clk) disable iff (!rstn)
    m_tlast |-> m_tvalid)
    else $error("m_tlast high without m_tvalid");

  // one pulse per run
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    done |=> !done)
    else $error("done held for more than one cycle");

endmodule

bind conv_engine conv_engine_properties u_props (
  .clk      (clk),
  .rstn     (rstn),
  .m_tdata  (m_tdata),
  .m_tvalid (m_tvalid),
  .m_tready (m_tready),
  .m_tlast  (m_tlast),
  .done     (done)
);

// ==== bench/conv_engine_tb.sv ====
// conv engine testbench with filter loads, window runs, reference model and output checks
`timescale 1ns/10ps

module conv_engine_tb;

  localparam int TOTAL_WIN = 38;  // windows over all runs
  localparam int TIMEOUT   = TOTAL_WIN * 40 + 200;

  logic                        clk;
  logic                        rstn;
  conv_pkg::cmd_e              cmd;
  logic [conv_pkg::DATA_W-1:0] s_tdata;
  logic                        s_tvalid;
  logic                        s_tready;
  logic                        s_tlast;
  logic [conv_pkg::DATA_W-1:0] m_tdata;
  logic                        m_tvalid;
  logic                        m_tready;
  logic                        m_tlast;
  logic                        done;

  logic signed [7:0] weights [9];
  logic signed [7:0] feats [9];
  logic signed [7:0] bias;

  logic [7:0]  exp_bytes [$];  // expected results in stream order
  logic        exp_end [$];    // result closes its run
  int unsigned seed;
  int unsigned rdy_seed;       // ready pattern has its own LCG state
  logic        bp_on;
  int          err_cnt, check_cnt, done_cnt, runs_sent, word_cnt, cycle_cnt;
  string       test_name;

  conv_engine UUT (
    .clk      (clk),
    .rstn     (rstn),
    .cmd      (cmd),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////////////////////////
  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] rand_byte();
    seed = lcg_step(seed);
    return seed[23:16];  // upper bits have the longer period
  endfunction

  // sum of products plus bias at the product fraction followed by ReLU and saturation
  function automatic logic [7:0] conv_ref(input logic signed [7:0] f [9],
                                          input logic signed [7:0] w [9],
                                          input logic signed [7:0] b);
    int acc;
    acc = int'(b) * 64;
    for (int i = 0; i < 9; i++) acc += int'(f[i]) * int'(w[i]);
    if (acc < 0) return 8'd0;
    else if (acc >= 8192) return 8'd127;  // anything above bit 12
    else return 8'(acc / 64);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      err_cnt++;
      $display("FAILED %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // input stream side
  //////////////////////////////////////////////////////////////////////
  // called at a falling edge and returns at the falling edge after the transfer
  task automatic send_word(input logic [31:0] data, input logic last);
    s_tdata  = data;
    s_tvalid = 1'b1;
    s_tlast  = last;
    while (!s_tready) @(negedge clk);
    @(negedge clk);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic issue_cmd(input conv_pkg::cmd_e c);
    cmd = c;
    @(negedge clk);
    cmd = conv_pkg::CMD_NOP;  // sampled in IDLE only
  endtask

  task automatic load_filter();
    issue_cmd(conv_pkg::CMD_LOAD_FILTER);
    send_word({weights[3], weights[2], weights[1], weights[0]}, 1'b0);
    send_word({weights[7], weights[6], weights[5], weights[4]}, 1'b0);
    send_word({rand_byte(), rand_byte(), bias, weights[8]}, 1'b0);  // top bytes unused
  endtask

  task automatic send_window(input logic last);
    exp_bytes.push_back(conv_ref(feats, weights, bias));
    exp_end.push_back(last);
    send_word({feats[3], feats[2], feats[1], feats[0]}, 1'b0);
    send_word({feats[7], feats[6], feats[5], feats[4]}, 1'b0);
    send_word({rand_byte(), rand_byte(), rand_byte(), feats[8]}, last);
  endtask

  task automatic finish_run(input int n_win, input int base);
    runs_sent++;
    while (done_cnt < runs_sent) @(negedge clk);
    compare_value({test_name, " words"}, (n_win + 3) / 4, word_cnt - base);
    compare_value({test_name, " pending"}, 0, exp_bytes.size());
  endtask

  task automatic run_random(input int n);
    int base;
    base = word_cnt;
    issue_cmd(conv_pkg::CMD_RUN);
    for (int i = 0; i < n; i++) begin
      foreach (feats[j]) feats[j] = rand_byte();
      send_window(i == n - 1);
    end
    finish_run(n, base);
  endtask

  //////////////////////////////////////////////////////////////////////
  // output side drives m_tready and compares each accepted word
  //////////////////////////////////////////////////////////////////////
  initial begin : monitor
    logic [7:0] want;
    logic       ended;
    m_tready = 1'b0;
    rdy_seed = 32'd77;
    forever begin
      @(negedge clk);
      if (bp_on) begin
        rdy_seed = lcg_step(rdy_seed);
        m_tready = rdy_seed[20];
      end else begin
        m_tready = 1'b1;
      end
      #1;  // outputs settled before the rising edge that decides the transfer
      if (done) done_cnt++;
      if (m_tvalid && m_tready) begin
        word_cnt++;
        ended = 1'b0;
        if (exp_bytes.size() == 0) begin
          err_cnt++;
          $display("output word arrived with no pending result in %s", test_name);
        end else begin
          for (int k = 0; k < 4; k++) begin
            want = 8'd0;  // lanes after the run's last result stay zero
            if (!ended) begin
              want  = exp_bytes.pop_front();
              ended = exp_end.pop_front();
            end
            compare_value($sformatf("%s lane %0d", test_name, k), want, m_tdata[8*k +: 8]);
          end
          compare_value({test_name, " tlast"}, ended, m_tlast);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout after %0d cycles in %s", cycle_cnt, test_name);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    int base;
    seed     = 32'd77;
    rstn     = 1'b0;
    cmd      = conv_pkg::CMD_NOP;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    bp_on    = 1'b0;
    test_name = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    compare_value("reset m_tvalid", 0, m_tvalid);
    compare_value("reset done", 0, done);
    compare_value("reset s_tready", 0, s_tready);

    // small weights keep most sums inside the unsaturated range
    test_name = "single";
    foreach (weights[i]) weights[i] = $signed(rand_byte()) >>> 3;
    bias = rand_byte();
    load_filter();
    run_random(1);

    test_name = "saturate";
    foreach (weights[i]) weights[i] = -8'sd128;
    bias = 8'sd20;
    load_filter();
    base = word_cnt;
    issue_cmd(conv_pkg::CMD_RUN);
    foreach (feats[i]) feats[i] = -8'sd128;  // large positive sum
    send_window(1'b0);
    foreach (feats[i]) feats[i] = 8'sd127;   // large negative sum
    send_window(1'b1);
    finish_run(2, base);

    test_name = "packing";
    foreach (weights[i]) weights[i] = $signed(rand_byte()) >>> 3;
    bias = rand_byte();
    load_filter();
    run_random(10);

    test_name = "backpressure";
    bp_on = 1'b1;
    run_random(20);
    bp_on = 1'b0;

    test_name = "reload";
    foreach (weights[i]) weights[i] = $signed(rand_byte()) >>> 2;
    bias = rand_byte();
    load_filter();
    run_random(5);

    repeat (5) @(negedge clk);
    compare_value("done pulses", runs_sent, done_cnt);
    $display("checks %0d errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/conv_pkg.sv
hdl/cla_adder.sv
hdl/mac_pipeline.sv
hdl/window_loader.sv
hdl/result_packer.sv
hdl/conv_engine.sv
bench/conv_engine_properties.sv
bench/conv_engine_tb.sv

// ==== hdl/cla_adder.sv ====
// 28-bit carry-lookahead adder from 4-bit groups with a group carry chain
`timescale 1ns/10ps

module cla_adder (
  input  logic [conv_pkg::ACC_W-1:0] a,
  input  logic [conv_pkg::ACC_W-1:0] b,
  output logic [conv_pkg::ACC_W-1:0] sum
);

  logic [conv_pkg::ACC_W-1:0]   p;   // bit propagate
  logic [conv_pkg::ACC_W-1:0]   g;   // bit generate
  logic [conv_pkg::ACC_W-1:0]   c;   // carry into each bit
  logic [conv_pkg::ACC_W/4-2:0] gp;  // group propagate, top group not needed
  logic [conv_pkg::ACC_W/4-2:0] gg;  // group generate
  logic [conv_pkg::ACC_W/4-1:0] gc;  // carry into each group

  assign p     = a ^ b;
  assign g     = a & b;
  assign gc[0] = 1'b0;  // add only, no carry in

  for (genvar i = 0; i < conv_pkg::ACC_W / 4; i++) begin : g_grp
    // carries inside the group straight from the group carry in
    assign c[4*i]   = gc[i];
    assign c[4*i+1] = g[4*i] | (p[4*i] & gc[i]);
    assign c[4*i+2] = g[4*i+1] | (p[4*i+1] & g[4*i]) |
                      (p[4*i+1] & p[4*i] & gc[i]);
    assign c[4*i+3] = g[4*i+2] | (p[4*i+2] & g[4*i+1]) |
                      (p[4*i+2] & p[4*i+1] & g[4*i]) |
                      (p[4*i+2] & p[4*i+1] & p[4*i] & gc[i]);

    assign sum[4*i +: 4] = p[4*i +: 4] ^ c[4*i +: 4];

    if (i < conv_pkg::ACC_W / 4 - 1) begin : g_look
      assign gp[i] = &p[4*i +: 4];
      assign gg[i] = g[4*i+3] |
                     (g[4*i+2] & p[4*i+3]) |
                     (g[4*i+1] & p[4*i+2] & p[4*i+3]) |
                     (g[4*i]   & p[4*i+1] & p[4*i+2] & p[4*i+3]);
      // lookahead chain to the next group
      assign gc[i+1] = gg[i] | (gp[i] & gc[i]);
    end
  end

endmodule

// ==== hdl/conv_engine.sv ====
// conv engine top: window loader feeding the MAC PE and the result packer
`timescale 1ns/10ps

module conv_engine (
  input  logic                        clk,
  input  logic                        rstn,
  input  conv_pkg::cmd_e              cmd,
  input  logic [conv_pkg::DATA_W-1:0] s_tdata,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  input  logic                        s_tlast,
  output logic [conv_pkg::DATA_W-1:0] m_tdata,
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output logic                        m_tlast,
  output logic                        done
);

  // loader to PE
  logic                               tap_valid, tap_first, tap_last, tap_end_run;
  logic signed [conv_pkg::BYTE_W-1:0] feat_tap, weight_tap;
  // PE to packer
  logic                               acc_valid, acc_end_run;
  logic signed [conv_pkg::ACC_W-1:0]  acc_sum;
  // loader and packer side band
  logic signed [conv_pkg::BYTE_W-1:0] bias;
  logic                               packer_busy;

  window_loader u_loader (
    .clk         (clk),
    .rstn        (rstn),
    .cmd         (cmd),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .s_tready    (s_tready),
    .packer_busy (packer_busy),
    .tap_valid   (tap_valid),
    .tap_first   (tap_first),
    .tap_last    (tap_last),
    .tap_end_run (tap_end_run),
    .feat_tap    (feat_tap),
    .weight_tap  (weight_tap),
    .bias        (bias)
  );

  mac_pipeline u_pe (
    .clk         (clk),
    .rstn        (rstn),
    .tap_valid   (tap_valid),
    .tap_first   (tap_first),
    .tap_last    (tap_last),
    .tap_end_run (tap_end_run),
    .feat_tap    (feat_tap),
    .weight_tap  (weight_tap),
    .acc_valid   (acc_valid),
    .acc_sum     (acc_sum),
    .acc_end_run (acc_end_run)
  );

  result_packer u_packer (
    .clk         (clk),
    .rstn        (rstn),
    .acc_valid   (acc_valid),
    .acc_sum     (acc_sum),
    .acc_end_run (acc_end_run),
    .bias        (bias),
    .m_tready    (m_tready),
    .m_tdata     (m_tdata),
    .m_tvalid    (m_tvalid),
    .m_tlast     (m_tlast),
    .done        (done),
    .packer_busy (packer_busy)
  );

endmodule

// ==== hdl/conv_pkg.sv ====
// conv engine shared package: stream and datapath widths, constants and enums
package conv_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////
  localparam int DATA_W      = 32;  // stream word
  localparam int BYTE_W      = 8;   // tap, weight, bias and result byte
  localparam int LANES       = 4;   // result bytes per output word
  localparam int TAPS        = 9;   // 3x3 window
  localparam int GROUP_WORDS = 3;   // words per filter load or window
  localparam int PROD_W      = 16;  // signed 8x8 product
  localparam int ACC_W       = 28;  // accumulator and adder width

  //////////////////////////////////////////////////////////////////////
  // output scaling
  //////////////////////////////////////////////////////////////////////
  // bias is aligned to the product fraction, result keeps bits 12..6
  localparam int FRAC_SHIFT = 6;
  localparam logic [BYTE_W-1:0] SAT_MAX = 8'd127;

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    CMD_NOP         = 2'd0,
    CMD_LOAD_FILTER = 2'd1,  // next three words carry weights and bias
    CMD_RUN         = 2'd2   // windows follow until tlast
  } cmd_e;

  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    LOAD_FILTER = 2'd1,
    LOAD_WINDOW = 2'd2,
    ISSUE       = 2'd3
  } loader_state_e;

endpackage

// ==== hdl/mac_pipeline.sv ====
// nine-stage signed multiply-accumulate PE, shift-and-add magnitude multiplier
`timescale 1ns/10ps

module mac_pipeline (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               tap_valid,
  input  logic                               tap_first,
  input  logic                               tap_last,
  input  logic                               tap_end_run,
  input  logic signed [conv_pkg::BYTE_W-1:0] feat_tap,
  input  logic signed [conv_pkg::BYTE_W-1:0] weight_tap,
  output logic                               acc_valid,
  output logic signed [conv_pkg::ACC_W-1:0]  acc_sum,
  output logic                               acc_end_run
);

  logic [conv_pkg::BYTE_W-1:0] a_mag, b_mag;
  logic                        prod_sign;

  // flags travelling with the data, index = stage
  logic [8:1] vld_sr, first_sr, last_sr, end_sr;
  logic [7:1] sign_sr;

  logic [7:0]  pp_s1 [8];                       // partial products
  logic [5:0]  lsb_s2 [4];
  logic [2:0]  pe_msb_s2 [4];                   // even pp bits 7:5
  logic [3:0]  po_msb_s2 [4];                   // odd pp bits 7:4
  logic [9:0]  sum_s3 [4];
  logic [7:0]  lsb_s4 [2];
  logic [2:0]  m_lo_s4 [2];
  logic [4:0]  m_hi_s4 [2];
  logic [11:0] sum_s5 [2];
  logic [9:0]  lsb_s6;
  logic [2:0]  m_lo_s6;
  logic [6:0]  m_hi_s6;
  logic [conv_pkg::PROD_W-1:0] mag_s7;
  logic [conv_pkg::PROD_W-1:0] prod_s8;

  logic [5:0]  lsb2_d [4];
  logic [4:0]  msb3_d [4];
  logic [7:0]  lsb4_d [2];
  logic [4:0]  msb5_d [2];
  logic [9:0]  lsb6_d;
  logic [6:0]  msb7_d;

  logic [conv_pkg::ACC_W-1:0] prod_ext, acc_base, acc_next;

  assign a_mag     = feat_tap[conv_pkg::BYTE_W-1] ? ~feat_tap + 1'b1 : feat_tap;
  assign b_mag     = weight_tap[conv_pkg::BYTE_W-1] ? ~weight_tap + 1'b1 : weight_tap;
  assign prod_sign = feat_tap[conv_pkg::BYTE_W-1] ^ weight_tap[conv_pkg::BYTE_W-1];

  //////////////////////////////////////////////////////////////////////
  // adder tree, split into low and high halves per stage
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int j = 0; j < 4; j++) begin
      lsb2_d[j] = pp_s1[2*j][4:0] + {pp_s1[2*j+1][3:0], 1'b0};
      msb3_d[j] = pe_msb_s2[j] + po_msb_s2[j] + lsb_s2[j][5];
    end
    for (int k = 0; k < 2; k++) begin
      lsb4_d[k] = sum_s3[2*k][6:0] + {sum_s3[2*k+1][4:0], 2'b0};
      msb5_d[k] = m_lo_s4[k] + m_hi_s4[k] + lsb_s4[k][7];
    end
    lsb6_d = sum_s5[0][8:0] + {sum_s5[1][4:0], 4'b0};
    msb7_d = m_lo_s6 + m_hi_s6 + lsb_s6[9];
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      pp_s1[i] <= b_mag[i] ? a_mag : '0;  // stage 1
    end
    for (int j = 0; j < 4; j++) begin
      lsb_s2[j]    <= lsb2_d[j];  // stage 2
      pe_msb_s2[j] <= pp_s1[2*j][7:5];
      po_msb_s2[j] <= pp_s1[2*j+1][7:4];
      sum_s3[j]    <= {msb3_d[j], lsb_s2[j][4:0]};  // stage 3
    end
    for (int k = 0; k < 2; k++) begin
      lsb_s4[k]  <= lsb4_d[k];  // stage 4
      m_lo_s4[k] <= sum_s3[2*k][9:7];
      m_hi_s4[k] <= sum_s3[2*k+1][9:5];
      sum_s5[k]  <= {msb5_d[k], lsb_s4[k][6:0]};  // stage 5
    end
    lsb_s6  <= lsb6_d;  // stage 6
    m_lo_s6 <= sum_s5[0][11:9];
    m_hi_s6 <= sum_s5[1][11:5];
    mag_s7  <= {msb7_d, lsb_s6[8:0]};  // stage 7
    prod_s8 <= sign_sr[7] ? ~mag_s7 + 1'b1 : mag_s7;  // stage 8, sign back
    sign_sr  <= {sign_sr[6:1], prod_sign};
    first_sr <= {first_sr[7:1], tap_first};
    last_sr  <= {last_sr[7:1], tap_last};
    end_sr   <= {end_sr[7:1], tap_end_run};
  end

  //////////////////////////////////////////////////////////////////////
  // stage 9 accumulate
  //////////////////////////////////////////////////////////////////////
  assign prod_ext = {{(conv_pkg::ACC_W-conv_pkg::PROD_W){prod_s8[conv_pkg::PROD_W-1]}},
                     prod_s8};
  assign acc_base = first_sr[8] ? '0 : acc_sum;  // first tap starts over

  cla_adder u_acc_add (
    .a   (prod_ext),
    .b   (acc_base),
    .sum (acc_next)
  );

  always_ff @(posedge clk) begin
    if (vld_sr[8]) begin
      acc_sum     <= acc_next;
      acc_end_run <= end_sr[8];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_sr    <= '0;
      acc_valid <= 1'b0;
    end else begin
      vld_sr    <= {vld_sr[7:1], tap_valid};
      acc_valid <= vld_sr[8] & last_sr[8];  // window sum complete
    end
  end

endmodule

// ==== hdl/result_packer.sv ====
// bias add, rectify and saturate, pack four result bytes into the output stream
`timescale 1ns/10ps

module result_packer (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               acc_valid,
  input  logic signed [conv_pkg::ACC_W-1:0]  acc_sum,
  input  logic                               acc_end_run,
  input  logic signed [conv_pkg::BYTE_W-1:0] bias,
  input  logic                               m_tready,
  output logic [conv_pkg::DATA_W-1:0]        m_tdata,
  output logic                               m_tvalid,
  output logic                               m_tlast,
  output logic                               done,
  output logic                               packer_busy
);

  logic [conv_pkg::ACC_W-1:0]  bias_ext;
  logic [conv_pkg::ACC_W-1:0]  biased;
  logic [conv_pkg::BYTE_W-1:0] res_byte;

  logic [conv_pkg::DATA_W-1:0] asm_data;  // assembly word
  logic [2:0]                  asm_cnt;   // lanes filled
  logic                        asm_last;  // holds the end of the run
  logic                        out_free;
  logic                        move;

  // bias aligned to the product fraction
  assign bias_ext = {{(conv_pkg::ACC_W-conv_pkg::BYTE_W-conv_pkg::FRAC_SHIFT){bias[7]}},
                     bias, {conv_pkg::FRAC_SHIFT{1'b0}}};

  cla_adder u_bias_add (
    .a   (acc_sum),
    .b   (bias_ext),
    .sum (biased)
  );

  //////////////////////////////////////////////////////////////////////
  // ReLU and saturation to a byte
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (biased[conv_pkg::ACC_W-1]) begin
      res_byte = '0;  // negative
    end else if (|biased[conv_pkg::ACC_W-2:conv_pkg::FRAC_SHIFT+conv_pkg::BYTE_W-1]) begin
      res_byte = conv_pkg::SAT_MAX;
    end else begin
      res_byte = {1'b0, biased[conv_pkg::FRAC_SHIFT+conv_pkg::BYTE_W-2:conv_pkg::FRAC_SHIFT]};
    end
  end

  assign out_free = !m_tvalid || m_tready;
  assign move     = out_free && (asm_cnt == 3'(conv_pkg::LANES) || asm_last);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      asm_cnt  <= '0;
      asm_last <= 1'b0;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else if (move) begin
      m_tvalid <= 1'b1;
      m_tlast  <= asm_last;
      asm_cnt  <= acc_valid ? 3'd1 : 3'd0;  // a new result may land at once
      asm_last <= acc_valid && acc_end_run;
    end else begin
      if (m_tvalid && m_tready) begin
        m_tvalid <= 1'b0;
        m_tlast  <= 1'b0;
      end
      if (acc_valid) begin
        asm_cnt  <= asm_cnt + 1'b1;
        asm_last <= acc_end_run;
      end
    end
  end

  // first lane clears the rest, so short last words carry zeros
  always_ff @(posedge clk) begin
    if (move) m_tdata <= asm_data;
    if (acc_valid) begin
      if (move || asm_cnt == '0) begin
        asm_data <= conv_pkg::DATA_W'(res_byte);
      end else begin
        asm_data[asm_cnt[1:0]*conv_pkg::BYTE_W +: conv_pkg::BYTE_W] <= res_byte;
      end
    end
  end

  assign done        = m_tvalid && m_tready && m_tlast;
  assign packer_busy = m_tvalid && (asm_cnt >= 3'd2);  // room for two in flight

endmodule

// ==== hdl/window_loader.sv ====
// input stream unpacker: holds filter, bias and window, issues nine taps per window
`timescale 1ns/10ps

module window_loader (
  input  logic                               clk,
  input  logic                               rstn,
  input  conv_pkg::cmd_e                     cmd,
  input  logic [conv_pkg::DATA_W-1:0]        s_tdata,
  input  logic                               s_tvalid,
  input  logic                               s_tlast,
  output logic                               s_tready,
  input  logic                               packer_busy,
  output logic                               tap_valid,
  output logic                               tap_first,
  output logic                               tap_last,
  output logic                               tap_end_run,
  output logic signed [conv_pkg::BYTE_W-1:0] feat_tap,
  output logic signed [conv_pkg::BYTE_W-1:0] weight_tap,
  output logic signed [conv_pkg::BYTE_W-1:0] bias
);

  conv_pkg::loader_state_e state;

  logic [1:0] word_cnt;  // word within a group
  logic [3:0] tap_cnt;
  logic       last_win;  // current window closes the run
  logic       xfer;

  logic [conv_pkg::TAPS*conv_pkg::BYTE_W-1:0] weight_reg;
  logic [conv_pkg::TAPS*conv_pkg::BYTE_W-1:0] win_reg;
  logic [conv_pkg::BYTE_W-1:0]                bias_reg;

  assign s_tready = (state == conv_pkg::LOAD_FILTER || state == conv_pkg::LOAD_WINDOW) &&
                    !packer_busy;
  assign xfer     = s_tvalid && s_tready;

  //////////////////////////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= conv_pkg::IDLE;
      word_cnt <= '0;
      tap_cnt  <= '0;
      last_win <= 1'b0;
    end else begin
      case (state)
        conv_pkg::IDLE: begin
          word_cnt <= '0;
          if (cmd == conv_pkg::CMD_LOAD_FILTER) state <= conv_pkg::LOAD_FILTER;
          else if (cmd == conv_pkg::CMD_RUN)    state <= conv_pkg::LOAD_WINDOW;
        end
        conv_pkg::LOAD_FILTER: begin
          if (xfer) begin
            if (word_cnt == 2'(conv_pkg::GROUP_WORDS - 1)) begin
              word_cnt <= '0;
              state    <= conv_pkg::IDLE;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        conv_pkg::LOAD_WINDOW: begin
          if (xfer) begin
            if (word_cnt == 2'(conv_pkg::GROUP_WORDS - 1)) begin
              word_cnt <= '0;
              tap_cnt  <= '0;
              last_win <= s_tlast;
              state    <= conv_pkg::ISSUE;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        conv_pkg::ISSUE: begin
          tap_cnt <= tap_cnt + 1'b1;
          if (tap_cnt == 4'(conv_pkg::TAPS - 1)) begin
            state <= last_win ? conv_pkg::IDLE : conv_pkg::LOAD_WINDOW;
          end
        end
        default: state <= conv_pkg::IDLE;
      endcase
    end
  end

  // byte collection, word 2 holds tap 8 and (for a filter) the bias
  always_ff @(posedge clk) begin
    if (xfer) begin
      if (state == conv_pkg::LOAD_FILTER) begin
        case (word_cnt)
          2'd0:    weight_reg[conv_pkg::DATA_W-1:0] <= s_tdata;
          2'd1:    weight_reg[2*conv_pkg::DATA_W-1:conv_pkg::DATA_W] <= s_tdata;
          default: begin
            weight_reg[conv_pkg::TAPS*conv_pkg::BYTE_W-1:2*conv_pkg::DATA_W] <=
              s_tdata[conv_pkg::BYTE_W-1:0];
            bias_reg <= s_tdata[2*conv_pkg::BYTE_W-1:conv_pkg::BYTE_W];
          end
        endcase
      end else begin
        case (word_cnt)
          2'd0:    win_reg[conv_pkg::DATA_W-1:0] <= s_tdata;
          2'd1:    win_reg[2*conv_pkg::DATA_W-1:conv_pkg::DATA_W] <= s_tdata;
          default: win_reg[conv_pkg::TAPS*conv_pkg::BYTE_W-1:2*conv_pkg::DATA_W] <=
                     s_tdata[conv_pkg::BYTE_W-1:0];
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tap issue, one per cycle in ISSUE
  //////////////////////////////////////////////////////////////////////
  assign tap_valid   = (state == conv_pkg::ISSUE);
  assign tap_first   = (tap_cnt == '0);
  assign tap_last    = (tap_cnt == 4'(conv_pkg::TAPS - 1));
  assign tap_end_run = last_win;
  assign feat_tap    = win_reg[tap_cnt*conv_pkg::BYTE_W +: conv_pkg::BYTE_W];
  assign weight_tap  = weight_reg[tap_cnt*conv_pkg::BYTE_W +: conv_pkg::BYTE_W];
  assign bias        = bias_reg;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the conv engine testbench with Verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module conv_engine_tb \
  -f flist.f -o conv_engine_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/conv_engine_sim > sim.log 2>&1

grep -q "Simulation PASSED" sim.log \
  && { echo "run passed"; exit 0; } \
  || { echo "run failed, see sim.log"; exit 1; }
